// File: source/eth_params.svh
`ifndef ETH_PARAMS_SVH
`define ETH_PARAMS_SVH

// Stream widths
`define ETH_DATA_W 64
`define ETH_KEEP_W 8

// Address widths
`define ETH_MAC_W 48
`define ETH_IP_W 32

// EtherType values
`define ETYPE_IPV4 16'h0800
`define ETYPE_ARP 16'h0806

// ARP field values, in network order
`define ARP_OPER_REQUEST 16'h0001
`define ARP_OPER_REPLY 16'h0002
`define ARP_HTYPE_ETH 16'h0001

// Version 4 with a five word header
`define IPV4_VER_IHL 8'h45

// 28 byte ARP body on a 64-bit stream
`define ARP_BEATS 4

`endif

// File: source/eth_pkg.sv
`default_nettype none

`include "eth_params.svh"

package eth_pkg;

    // Ethernet header, held constant on every beat of a frame
    typedef struct packed {
        logic [`ETH_MAC_W-1:0] dest_mac;
        logic [`ETH_MAC_W-1:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // One stream beat
    // Lane 0 sits in data[7:0] and carries the earliest byte
    typedef struct packed {
        eth_hdr_t hdr;
        logic [`ETH_DATA_W-1:0] data;
        logic [`ETH_KEEP_W-1:0] keep;
        logic last;
        // Set on any beat of a bad frame
        logic user;
    } eth_beat_t;

endpackage

`default_nettype wire

// File: source/eth_type_demux.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_params.svh"

module eth_type_demux (
    input wire clk,
    input wire rst,

    input wire eth_pkg::eth_beat_t in_beat,
    input wire in_valid,
    output logic in_ready,

    output eth_pkg::eth_beat_t ip_beat,
    output logic ip_valid,
    input wire ip_ready,

    output eth_pkg::eth_beat_t arp_beat,
    output logic arp_valid,
    input wire arp_ready
);

    typedef enum logic [1:0] {
        ROUTE_NONE,
        ROUTE_IP,
        ROUTE_ARP,
        ROUTE_DROP
    } route_t;

    route_t route_q;
    route_t route_new;
    route_t route;

    // Decode of the EtherType on the current beat
    always_comb begin
        case (in_beat.hdr.eth_type)
            `ETYPE_IPV4: route_new = ROUTE_IP;
            `ETYPE_ARP: route_new = ROUTE_ARP;
            default: route_new = ROUTE_DROP;
        endcase
    end

    // First beat is steered straight from the decode
    assign route = (route_q == ROUTE_NONE) ? route_new : route_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            route_q <= ROUTE_NONE;
        end else if (in_valid && in_ready && in_beat.last) begin
            route_q <= ROUTE_NONE;
        end else if (in_valid && route_q == ROUTE_NONE) begin
            route_q <= route_new;
        end
    end

    assign ip_beat = in_beat;
    assign arp_beat = in_beat;
    assign ip_valid = in_valid && (route == ROUTE_IP);
    assign arp_valid = in_valid && (route == ROUTE_ARP);

    // Dropped frames are swallowed at full rate
    always_comb begin
        case (route)
            ROUTE_IP: in_ready = ip_ready;
            ROUTE_ARP: in_ready = arp_ready;
            default: in_ready = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: source/ip_rx_check.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_params.svh"

module ip_rx_check (
    input wire clk,
    input wire rst,

    input wire eth_pkg::eth_beat_t in_beat,
    input wire in_valid,
    output logic in_ready,

    output eth_pkg::eth_beat_t out_beat,
    output logic out_valid,
    input wire out_ready,

    output logic rx_error_invalid_header
);

    logic first_q;
    logic bad_q;
    logic bad_first;
    logic bad_now;
    logic xfer;

    assign xfer = in_valid && in_ready;

    // Byte 0 of the IP header holds version and IHL
    assign bad_first = (in_beat.data[7:0] != `IPV4_VER_IHL);
    assign bad_now = first_q ? bad_first : bad_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            first_q <= 1'b1;
            bad_q <= 1'b0;
            rx_error_invalid_header <= 1'b0;
        end else begin
            rx_error_invalid_header <= xfer && first_q && bad_first;
            if (xfer) begin
                first_q <= in_beat.last;
                if (first_q) begin
                    bad_q <= bad_first;
                end
            end
        end
    end

    assign out_valid = in_valid;
    assign in_ready = out_ready;

    always_comb begin
        out_beat = in_beat;
        // Mark the whole frame bad
        out_beat.user = in_beat.user | bad_now;
    end

endmodule

`default_nettype wire

// File: source/arp_responder.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_params.svh"

module arp_responder (
    input wire clk,
    input wire rst,

    input wire eth_pkg::eth_beat_t in_beat,
    input wire in_valid,
    output logic in_ready,

    output eth_pkg::eth_beat_t out_beat,
    output logic out_valid,
    input wire out_ready,

    input wire [`ETH_MAC_W-1:0] local_mac,
    input wire [`ETH_IP_W-1:0] local_ip
);

    import eth_pkg::*;

    // Reorders lanes so the earliest byte lands in the MSB
    function automatic logic [`ETH_DATA_W-1:0] lane_swap(input logic [`ETH_DATA_W-1:0] w);
        logic [`ETH_DATA_W-1:0] r;
        for (int i = 0; i < `ETH_KEEP_W; i++) begin
            r[8*i +: 8] = w[8*(`ETH_KEEP_W-1-i) +: 8];
        end
        return r;
    endfunction

    logic [2:0] rx_cnt;
    logic [1:0] tx_cnt;
    logic req_bad;
    logic reply_active;

    logic [15:0] req_htype;
    logic [15:0] req_ptype;
    logic [15:0] req_oper;
    logic [`ETH_MAC_W-1:0] req_mac;
    logic [`ETH_IP_W-1:0] req_ip;
    logic [`ETH_IP_W-1:0] req_tpa;

    logic [`ETH_DATA_W-1:0] rx_word;
    logic [`ETH_IP_W-1:0] tpa_now;
    logic in_xfer;
    logic out_xfer;
    logic qualify;
    eth_hdr_t reply_hdr;

    assign in_ready = !reply_active;
    assign out_valid = reply_active;
    assign in_xfer = in_valid && in_ready;
    assign out_xfer = out_valid && out_ready;

    assign rx_word = lane_swap(in_beat.data);

    // Target IP arrives on beat 3, which may also be the last beat
    assign tpa_now = (rx_cnt == 3'(`ARP_BEATS - 1)) ? rx_word[63:32] : req_tpa;

    assign qualify = (rx_cnt >= 3'(`ARP_BEATS - 1)) &&
                     (req_htype == `ARP_HTYPE_ETH) &&
                     (req_ptype == `ETYPE_IPV4) &&
                     (req_oper == `ARP_OPER_REQUEST) &&
                     (tpa_now == local_ip) &&
                     !req_bad && !in_beat.user;

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_cnt <= '0;
            tx_cnt <= '0;
            req_bad <= 1'b0;
            reply_active <= 1'b0;
        end else begin
            if (in_xfer) begin
                if (in_beat.last) begin
                    rx_cnt <= '0;
                    req_bad <= 1'b0;
                    reply_active <= qualify;
                end else begin
                    // Stop counting on padding
                    if (rx_cnt != 3'(`ARP_BEATS)) begin
                        rx_cnt <= rx_cnt + 3'd1;
                    end
                    req_bad <= req_bad | in_beat.user;
                end
            end
            if (out_xfer) begin
                if (out_beat.last) begin
                    tx_cnt <= '0;
                    reply_active <= 1'b0;
                end else begin
                    tx_cnt <= tx_cnt + 2'd1;
                end
            end
        end
    end

    // Request fields, captured per body beat
    always_ff @(posedge clk) begin
        if (in_xfer) begin
            case (rx_cnt)
                3'd0: begin
                    req_htype <= rx_word[63:48];
                    req_ptype <= rx_word[47:32];
                    req_oper <= rx_word[15:0];
                end
                3'd1: begin
                    req_mac <= rx_word[63:16];
                    req_ip[31:16] <= rx_word[15:0];
                end
                3'd2: begin
                    req_ip[15:0] <= rx_word[63:48];
                end
                3'd3: begin
                    req_tpa <= rx_word[63:32];
                end
                default: begin
                end
            endcase
        end
    end

    assign reply_hdr.dest_mac = req_mac;
    assign reply_hdr.src_mac = local_mac;
    assign reply_hdr.eth_type = `ETYPE_ARP;

    // Reply body, one beat per value of tx_cnt
    always_comb begin
        out_beat.hdr = reply_hdr;
        out_beat.keep = '1;
        out_beat.last = 1'b0;
        out_beat.user = 1'b0;
        case (tx_cnt)
            2'd0: out_beat.data = lane_swap({`ARP_HTYPE_ETH, `ETYPE_IPV4,
                                             8'(`ETH_MAC_W / 8), 8'(`ETH_IP_W / 8),
                                             `ARP_OPER_REPLY});
            2'd1: out_beat.data = lane_swap({local_mac, local_ip[31:16]});
            2'd2: out_beat.data = lane_swap({local_ip[15:0], req_mac});
            default: out_beat.data = lane_swap({req_ip, 32'h0});
        endcase
        if (tx_cnt == 2'(`ARP_BEATS - 1)) begin
            // Only the target IP is left
            out_beat.keep = 8'h0F;
            out_beat.last = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/eth_tx_arb.sv
`timescale 1ns/1ps
`default_nettype none

module eth_tx_arb (
    input wire clk,
    input wire rst,

    input wire eth_pkg::eth_beat_t arp_beat,
    input wire arp_valid,
    output logic arp_ready,

    input wire eth_pkg::eth_beat_t ip_beat,
    input wire ip_valid,
    output logic ip_ready,

    output eth_pkg::eth_beat_t out_beat,
    output logic out_valid,
    input wire out_ready
);

    // grant 0 selects ARP, 1 selects IP
    logic busy_q;
    logic grant_q;
    logic sel;

    // ARP wins whenever no frame is open
    assign sel = busy_q ? grant_q : !arp_valid;

    assign out_beat = sel ? ip_beat : arp_beat;
    assign out_valid = sel ? ip_valid : arp_valid;
    assign arp_ready = !sel && out_ready;
    assign ip_ready = sel && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            grant_q <= 1'b0;
        end else if (out_valid && out_ready && out_beat.last) begin
            busy_q <= 1'b0;
        end else if (!busy_q && out_valid) begin
            // Lock the grant until this frame's last beat
            busy_q <= 1'b1;
            grant_q <= sel;
        end
    end

endmodule

`default_nettype wire

// File: source/ip_arp_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_params.svh"

module ip_arp_top (
    input wire clk,
    input wire rst,

    // Receive from the MAC
    input wire eth_pkg::eth_beat_t eth_rx_beat,
    input wire eth_rx_valid,
    output logic eth_rx_ready,

    // IPv4 receive
    output eth_pkg::eth_beat_t ip_rx_beat,
    output logic ip_rx_valid,
    input wire ip_rx_ready,

    // IPv4 transmit, Ethernet header already in place
    input wire eth_pkg::eth_beat_t ip_tx_beat,
    input wire ip_tx_valid,
    output logic ip_tx_ready,

    // Transmit to the MAC
    output eth_pkg::eth_beat_t eth_tx_beat,
    output logic eth_tx_valid,
    input wire eth_tx_ready,

    input wire [`ETH_MAC_W-1:0] local_mac,
    input wire [`ETH_IP_W-1:0] local_ip,

    output logic rx_error_invalid_header
);

    import eth_pkg::*;

    eth_beat_t dmx_ip_beat;
    logic dmx_ip_valid;
    logic dmx_ip_ready;

    eth_beat_t dmx_arp_beat;
    logic dmx_arp_valid;
    logic dmx_arp_ready;

    eth_beat_t arp_tx_beat;
    logic arp_tx_valid;
    logic arp_tx_ready;

    eth_type_demux demux0 (
        .clk(clk),
        .rst(rst),
        .in_beat(eth_rx_beat),
        .in_valid(eth_rx_valid),
        .in_ready(eth_rx_ready),
        .ip_beat(dmx_ip_beat),
        .ip_valid(dmx_ip_valid),
        .ip_ready(dmx_ip_ready),
        .arp_beat(dmx_arp_beat),
        .arp_valid(dmx_arp_valid),
        .arp_ready(dmx_arp_ready)
    );

    ip_rx_check ip_check0 (
        .clk(clk),
        .rst(rst),
        .in_beat(dmx_ip_beat),
        .in_valid(dmx_ip_valid),
        .in_ready(dmx_ip_ready),
        .out_beat(ip_rx_beat),
        .out_valid(ip_rx_valid),
        .out_ready(ip_rx_ready),
        .rx_error_invalid_header(rx_error_invalid_header)
    );

    arp_responder arp0 (
        .clk(clk),
        .rst(rst),
        .in_beat(dmx_arp_beat),
        .in_valid(dmx_arp_valid),
        .in_ready(dmx_arp_ready),
        .out_beat(arp_tx_beat),
        .out_valid(arp_tx_valid),
        .out_ready(arp_tx_ready),
        .local_mac(local_mac),
        .local_ip(local_ip)
    );

    // ARP replies take priority over user traffic
    eth_tx_arb arb0 (
        .clk(clk),
        .rst(rst),
        .arp_beat(arp_tx_beat),
        .arp_valid(arp_tx_valid),
        .arp_ready(arp_tx_ready),
        .ip_beat(ip_tx_beat),
        .ip_valid(ip_tx_valid),
        .ip_ready(ip_tx_ready),
        .out_beat(eth_tx_beat),
        .out_valid(eth_tx_valid),
        .out_ready(eth_tx_ready)
    );

endmodule

`default_nettype wire

// File: dv/ip_arp_assert.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_params.svh"

module ip_arp_assert (
    input wire clk,
    input wire rst,
    input wire eth_pkg::eth_beat_t eth_rx_beat,
    input wire eth_rx_valid,
    input wire eth_rx_ready,
    input wire eth_pkg::eth_beat_t ip_rx_beat,
    input wire ip_rx_valid,
    input wire ip_rx_ready,
    input wire eth_pkg::eth_beat_t ip_tx_beat,
    input wire ip_tx_valid,
    input wire ip_tx_ready,
    input wire eth_pkg::eth_beat_t eth_tx_beat,
    input wire eth_tx_valid,
    input wire eth_tx_ready,
    input wire [`ETH_MAC_W-1:0] local_mac,
    input wire [`ETH_IP_W-1:0] local_ip,
    input wire rx_error_invalid_header
);

    import eth_pkg::*;

    int err_cnt = 0;

    // Received ARP body, byte 0 first
    logic [7:0] rx_body [0:31];
    logic [2:0] rx_idx;
    logic rx_user;
    logic rx_done;
    logic arp_pending;
    logic arp_due;

    logic ip_first;
    logic ip_bad;
    logic bad_first_xfer;

    logic tx_open;
    logic [15:0] tx_type;
    logic [1:0] tx_idx;

    logic is_ipv4;
    logic is_arp_rx;
    logic is_arp_tx;

    assign is_ipv4 = (eth_rx_beat.hdr.eth_type == `ETYPE_IPV4);
    assign is_arp_rx = (eth_rx_beat.hdr.eth_type == `ETYPE_ARP);
    assign is_arp_tx = (eth_tx_beat.hdr.eth_type == `ETYPE_ARP);
    assign bad_first_xfer = ip_rx_valid && ip_rx_ready && ip_first &&
                            (ip_rx_beat.data[7:0] != `IPV4_VER_IHL);

    function automatic logic arp_qualifies(input logic [`ETH_IP_W-1:0] ip);
        return ({rx_body[0], rx_body[1]} == `ARP_HTYPE_ETH) &&
               ({rx_body[2], rx_body[3]} == `ETYPE_IPV4) &&
               ({rx_body[6], rx_body[7]} == `ARP_OPER_REQUEST) &&
               ({rx_body[24], rx_body[25], rx_body[26], rx_body[27]} == ip);
    endfunction

    // Expected byte n of the reply body
    function automatic logic [7:0] reply_byte(input int n);
        logic [63:0] fixed;
        fixed = {`ARP_HTYPE_ETH, `ETYPE_IPV4, 8'd6, 8'd4, `ARP_OPER_REPLY};
        if (n < 8) begin
            return fixed[63-8*n -: 8];
        end else if (n < 14) begin
            return local_mac[47-8*(n-8) -: 8];
        end else if (n < 18) begin
            return local_ip[31-8*(n-14) -: 8];
        end
        // Target fields mirror the requester's sender fields
        return rx_body[n-10];
    endfunction

    function automatic logic reply_beat_ok(input eth_beat_t b, input logic [1:0] idx);
        logic ok;
        ok = (b.hdr.src_mac == local_mac) && (b.last == (idx == 2'd3)) &&
             (b.keep == ((idx == 2'd3) ? 8'h0F : 8'hFF));
        for (int i = 0; i < 6; i++) begin
            ok &= (b.hdr.dest_mac[47-8*i -: 8] == rx_body[8+i]);
        end
        for (int l = 0; l < 8; l++) begin
            if (b.keep[l]) begin
                ok &= (b.data[8*l +: 8] == reply_byte(8*idx + l));
            end
        end
        return ok;
    endfunction

    always_comb begin
        arp_due = arp_pending || (rx_done && !rx_user && arp_qualifies(local_ip));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_idx <= '0;
            rx_user <= 1'b0;
            rx_done <= 1'b0;
            arp_pending <= 1'b0;
            ip_first <= 1'b1;
            ip_bad <= 1'b0;
            tx_open <= 1'b0;
            tx_idx <= '0;
        end else begin
            rx_done <= 1'b0;
            if (rx_done) begin
                rx_user <= 1'b0;
                if (arp_due) begin
                    arp_pending <= 1'b1;
                end
            end
            if (eth_rx_valid && eth_rx_ready && is_arp_rx) begin
                if (rx_idx < 3'd4) begin
                    for (int l = 0; l < 8; l++) begin
                        rx_body[8*rx_idx + l] <= eth_rx_beat.data[8*l +: 8];
                    end
                    rx_idx <= rx_idx + 3'd1;
                end
                rx_user <= (rx_done ? 1'b0 : rx_user) | eth_rx_beat.user;
                if (eth_rx_beat.last) begin
                    rx_idx <= '0;
                    rx_done <= 1'b1;
                end
            end
            if (ip_rx_valid && ip_rx_ready) begin
                ip_first <= ip_rx_beat.last;
                if (ip_first) begin
                    ip_bad <= (ip_rx_beat.data[7:0] != `IPV4_VER_IHL);
                end
            end
            // A frame opens once its first beat is presented
            if (eth_tx_valid && eth_tx_ready && eth_tx_beat.last) begin
                tx_open <= 1'b0;
            end else if (eth_tx_valid) begin
                tx_open <= 1'b1;
            end
            if (eth_tx_valid && !tx_open) begin
                tx_type <= eth_tx_beat.hdr.eth_type;
            end
            if (eth_tx_valid && eth_tx_ready && is_arp_tx) begin
                tx_idx <= eth_tx_beat.last ? 2'd0 : tx_idx + 2'd1;
                if (eth_tx_beat.last) begin
                    arp_pending <= 1'b0;
                end
            end
        end
    end

    a_ip_pass: assert property (@(posedge clk) disable iff (rst)
        eth_rx_valid && is_ipv4 |-> ip_rx_valid && (eth_rx_ready == ip_rx_ready) &&
            (ip_rx_beat.hdr == eth_rx_beat.hdr) && (ip_rx_beat.data == eth_rx_beat.data) &&
            (ip_rx_beat.keep == eth_rx_beat.keep) && (ip_rx_beat.last == eth_rx_beat.last))
    else begin
        $error("IPv4 beat not passed through to ip_rx");
        err_cnt++;
    end

    a_ip_only: assert property (@(posedge clk) disable iff (rst)
        ip_rx_valid |-> eth_rx_valid && is_ipv4)
    else begin
        $error("ip_rx valid without an IPv4 beat on eth_rx");
        err_cnt++;
    end

    a_bad_user: assert property (@(posedge clk) disable iff (rst)
        ip_rx_valid && (ip_first ? (ip_rx_beat.data[7:0] != `IPV4_VER_IHL) : ip_bad)
            |-> ip_rx_beat.user)
    else begin
        $error("Bad IPv4 header frame without user flag");
        err_cnt++;
    end

    a_err_pulse: assert property (@(posedge clk) disable iff (rst)
        rx_error_invalid_header == $past(bad_first_xfer))
    else begin
        $error("rx_error_invalid_header does not match failing first beats");
        err_cnt++;
    end

    a_drop_ready: assert property (@(posedge clk) disable iff (rst)
        eth_rx_valid && !is_ipv4 && !is_arp_rx |-> eth_rx_ready)
    else begin
        $error("Dropped frame saw eth_rx_ready low");
        err_cnt++;
    end

    a_reply_beat: assert property (@(posedge clk) disable iff (rst)
        eth_tx_valid && is_arp_tx |-> arp_due && reply_beat_ok(eth_tx_beat, tx_idx))
    else begin
        $error("Wrong or unrequested ARP reply beat on eth_tx");
        err_cnt++;
    end

    // Non-ARP transmit beats come only from ip_tx
    a_ip_tx_pass: assert property (@(posedge clk) disable iff (rst)
        eth_tx_valid && !is_arp_tx |-> ip_tx_valid && (eth_tx_beat == ip_tx_beat))
    else begin
        $error("eth_tx beat does not match the ip_tx beat");
        err_cnt++;
    end

    a_ip_tx_ready: assert property (@(posedge clk) disable iff (rst)
        ip_tx_valid |-> ip_tx_ready == (eth_tx_valid && !is_arp_tx && eth_tx_ready))
    else begin
        $error("ip_tx_ready does not follow the transmit grant");
        err_cnt++;
    end

    a_type_hold: assert property (@(posedge clk) disable iff (rst)
        eth_tx_valid && tx_open |-> eth_tx_beat.hdr.eth_type == tx_type)
    else begin
        $error("eth_tx EtherType changed inside a frame");
        err_cnt++;
    end

    a_arp_first: assert property (@(posedge clk) disable iff (rst)
        !tx_open && arp_due && ip_tx_valid |-> eth_tx_valid && is_arp_tx)
    else begin
        $error("ip_tx frame granted ahead of a waiting ARP reply");
        err_cnt++;
    end

    a_tx_stable: assert property (@(posedge clk) disable iff (rst)
        eth_tx_valid && !eth_tx_ready |=> eth_tx_valid && $stable(eth_tx_beat))
    else begin
        $error("eth_tx beat changed while stalled");
        err_cnt++;
    end

    a_rx_stable: assert property (@(posedge clk) disable iff (rst)
        ip_rx_valid && !ip_rx_ready |=> ip_rx_valid && $stable(ip_rx_beat))
    else begin
        $error("ip_rx beat changed while stalled");
        err_cnt++;
    end

    a_reset_idle: assert property (@(posedge clk)
        $fell(rst) |-> !eth_tx_valid && !ip_rx_valid && !rx_error_invalid_header)
    else begin
        $error("Outputs active right after reset");
        err_cnt++;
    end

endmodule

`default_nettype wire

// File: dv/ip_arp_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "eth_params.svh"

module ip_arp_tb;

    import eth_pkg::*;

    typedef logic [`ETH_DATA_W-1:0] word_q_t[$];

    localparam int FRAME_CNT = 13;
    // 40 cycles of 4 ns per frame plus some slack
    localparam int WATCHDOG_NS = FRAME_CNT * 40 * 4 + 400;

    localparam logic [47:0] LOCAL_MAC = 48'h02_00_00_0a_0b_0c;
    localparam logic [31:0] LOCAL_IP = 32'hc0_a8_01_64;
    localparam logic [31:0] OTHER_IP = 32'hc0_a8_01_65;
    localparam logic [47:0] PEER_A_MAC = 48'h02_11_22_33_44_55;
    localparam logic [31:0] PEER_A_IP = 32'hc0_a8_01_0a;
    localparam logic [47:0] PEER_B_MAC = 48'h02_66_77_88_99_aa;
    localparam logic [31:0] PEER_B_IP = 32'hc0_a8_01_0b;
    localparam logic [47:0] BCAST_MAC = 48'hff_ff_ff_ff_ff_ff;

    logic clk = 1'b0;
    logic rst;
    eth_beat_t eth_rx_beat;
    logic eth_rx_valid;
    logic eth_rx_ready;
    eth_beat_t ip_rx_beat;
    logic ip_rx_valid;
    logic ip_rx_ready;
    eth_beat_t ip_tx_beat;
    logic ip_tx_valid;
    logic ip_tx_ready;
    eth_beat_t eth_tx_beat;
    logic eth_tx_valid;
    logic eth_tx_ready;
    logic [47:0] local_mac;
    logic [31:0] local_ip;
    logic rx_error_invalid_header;

    int reply_exp = 0;
    int reply_seen = 0;
    int check_errs = 0;

    always #2 clk = ~clk;

    ip_arp_top dut0 (
        .clk(clk),
        .rst(rst),
        .eth_rx_beat(eth_rx_beat),
        .eth_rx_valid(eth_rx_valid),
        .eth_rx_ready(eth_rx_ready),
        .ip_rx_beat(ip_rx_beat),
        .ip_rx_valid(ip_rx_valid),
        .ip_rx_ready(ip_rx_ready),
        .ip_tx_beat(ip_tx_beat),
        .ip_tx_valid(ip_tx_valid),
        .ip_tx_ready(ip_tx_ready),
        .eth_tx_beat(eth_tx_beat),
        .eth_tx_valid(eth_tx_valid),
        .eth_tx_ready(eth_tx_ready),
        .local_mac(local_mac),
        .local_ip(local_ip),
        .rx_error_invalid_header(rx_error_invalid_header)
    );

    bind ip_arp_top ip_arp_assert assert0 (
        .clk(clk),
        .rst(rst),
        .eth_rx_beat(eth_rx_beat),
        .eth_rx_valid(eth_rx_valid),
        .eth_rx_ready(eth_rx_ready),
        .ip_rx_beat(ip_rx_beat),
        .ip_rx_valid(ip_rx_valid),
        .ip_rx_ready(ip_rx_ready),
        .ip_tx_beat(ip_tx_beat),
        .ip_tx_valid(ip_tx_valid),
        .ip_tx_ready(ip_tx_ready),
        .eth_tx_beat(eth_tx_beat),
        .eth_tx_valid(eth_tx_valid),
        .eth_tx_ready(eth_tx_ready),
        .local_mac(local_mac),
        .local_ip(local_ip),
        .rx_error_invalid_header(rx_error_invalid_header)
    );

    // Completed ARP replies on the transmit port
    always @(posedge clk) begin
        if (!rst && eth_tx_valid && eth_tx_ready && eth_tx_beat.last &&
            eth_tx_beat.hdr.eth_type == `ETYPE_ARP) begin
            reply_seen <= reply_seen + 1;
        end
    end

    function automatic eth_hdr_t make_hdr(input logic [47:0] dst, input logic [47:0] src,
                                          input logic [15:0] etype);
        eth_hdr_t h;
        h.dest_mac = dst;
        h.src_mac = src;
        h.eth_type = etype;
        return h;
    endfunction

    function automatic word_q_t random_words(input int n, input logic [7:0] first_byte);
        word_q_t q;
        for (int i = 0; i < n; i++) begin
            q.push_back({$urandom, $urandom});
        end
        q[0][7:0] = first_byte;
        return q;
    endfunction

    // ARP request body in four beats, earliest byte in lane 0
    function automatic word_q_t arp_request_words(input logic [47:0] sha,
                                                  input logic [31:0] spa,
                                                  input logic [31:0] tpa);
        logic [255:0] body;
        word_q_t q;
        body = {`ARP_HTYPE_ETH, `ETYPE_IPV4, 8'd6, 8'd4, `ARP_OPER_REQUEST,
                sha, spa, 48'h0, tpa, 32'h0};
        for (int w = 0; w < `ARP_BEATS; w++) begin
            q.push_back('0);
            for (int l = 0; l < 8; l++) begin
                q[w][8*l +: 8] = body[255 - 8*(8*w + l) -: 8];
            end
        end
        return q;
    endfunction

    task automatic send_rx_frame(input eth_hdr_t hdr, input word_q_t words, input logic bad);
        foreach (words[i]) begin
            @(negedge clk);
            eth_rx_beat.hdr = hdr;
            eth_rx_beat.data = words[i];
            eth_rx_beat.keep = '1;
            eth_rx_beat.last = (i == words.size() - 1);
            eth_rx_beat.user = bad;
            eth_rx_valid = 1'b1;
            // Ready has settled a nanosecond before the rising edge
            #1;
            while (!eth_rx_ready) begin
                @(negedge clk);
                #1;
            end
            @(posedge clk);
        end
        @(negedge clk);
        eth_rx_valid = 1'b0;
    endtask

    task automatic send_tx_frame(input eth_hdr_t hdr, input word_q_t words, input logic more);
        foreach (words[i]) begin
            @(negedge clk);
            ip_tx_beat.hdr = hdr;
            ip_tx_beat.data = words[i];
            ip_tx_beat.keep = '1;
            ip_tx_beat.last = (i == words.size() - 1);
            ip_tx_beat.user = 1'b0;
            ip_tx_valid = 1'b1;
            #1;
            while (!ip_tx_ready) begin
                @(negedge clk);
                #1;
            end
            @(posedge clk);
        end
        // Back to back frames keep valid up
        if (!more) begin
            @(negedge clk);
            ip_tx_valid = 1'b0;
        end
    endtask

    task automatic toggle_ready();
        forever begin
            @(negedge clk);
            eth_tx_ready = ($urandom_range(3) != 0);
            ip_rx_ready = ($urandom_range(3) != 0);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Run timed out at %0t before all frames finished", $time);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        eth_hdr_t ip_in_hdr;
        eth_hdr_t ip_out_hdr;
        void'($urandom(32'h9ce6_e752));
        rst = 1'b1;
        eth_rx_beat = '0;
        eth_rx_valid = 1'b0;
        ip_tx_beat = '0;
        ip_tx_valid = 1'b0;
        ip_rx_ready = 1'b1;
        eth_tx_ready = 1'b1;
        local_mac = LOCAL_MAC;
        local_ip = LOCAL_IP;
        ip_in_hdr = make_hdr(LOCAL_MAC, PEER_A_MAC, `ETYPE_IPV4);
        ip_out_hdr = make_hdr(PEER_B_MAC, LOCAL_MAC, `ETYPE_IPV4);
        repeat (5) @(negedge clk);
        rst = 1'b0;
        fork
            toggle_ready();
        join_none

        send_rx_frame(ip_in_hdr, random_words(3, 8'h45), 1'b0);
        send_rx_frame(ip_in_hdr, random_words(2, 8'h46), 1'b0);
        send_rx_frame(make_hdr(BCAST_MAC, PEER_A_MAC, `ETYPE_ARP),
                      arp_request_words(PEER_A_MAC, PEER_A_IP, LOCAL_IP), 1'b0);
        reply_exp++;
        send_rx_frame(make_hdr(BCAST_MAC, PEER_A_MAC, `ETYPE_ARP),
                      arp_request_words(PEER_A_MAC, PEER_A_IP, OTHER_IP), 1'b0);
        send_rx_frame(make_hdr(LOCAL_MAC, PEER_B_MAC, 16'h88B5), random_words(2, 8'h45), 1'b0);
        send_rx_frame(ip_in_hdr, random_words(1, 8'h45), 1'b0);
        send_rx_frame(ip_in_hdr, random_words(1, 8'h44), 1'b0);
        // Marked bad, so no reply
        send_rx_frame(make_hdr(BCAST_MAC, PEER_B_MAC, `ETYPE_ARP),
                      arp_request_words(PEER_B_MAC, PEER_B_IP, LOCAL_IP), 1'b1);

        // Request lands while a long ip_tx frame is open
        fork
            begin
                send_tx_frame(ip_out_hdr, random_words(6, 8'h45), 1'b1);
                send_tx_frame(ip_out_hdr, random_words(3, 8'h45), 1'b0);
            end
            begin
                repeat (2) @(negedge clk);
                send_rx_frame(make_hdr(BCAST_MAC, PEER_B_MAC, `ETYPE_ARP),
                              arp_request_words(PEER_B_MAC, PEER_B_IP, LOCAL_IP), 1'b0);
            end
        join
        reply_exp++;
        fork
            send_tx_frame(ip_out_hdr, random_words(4, 8'h45), 1'b0);
            send_rx_frame(make_hdr(BCAST_MAC, PEER_A_MAC, `ETYPE_ARP),
                          arp_request_words(PEER_A_MAC, PEER_A_IP, LOCAL_IP), 1'b0);
        join
        reply_exp++;

        for (int i = 0; i < 200 && (reply_seen < reply_exp || eth_tx_valid); i++) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);

        if (reply_seen != reply_exp) begin
            $display("** Error (%0t): expected %0d ARP replies on eth_tx, saw %0d",
                     $time, reply_exp, reply_seen);
            check_errs++;
        end
        $display("Errors: %0d assertion failures, %0d testbench check failures",
                 dut0.assert0.err_cnt, check_errs);
        if (dut0.assert0.err_cnt == 0 && check_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+source
source/eth_pkg.sv
source/eth_type_demux.sv
source/ip_rx_check.sv
source/arp_responder.sv
source/eth_tx_arb.sv
source/ip_arp_top.sv
dv/ip_arp_assert.sv
dv/ip_arp_tb.sv
